/* ex_stage.f */
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_mult.sv
rtl/ex_offload_disp.sv
rtl/ex_writeback.sv
rtl/ex_stage.sv
verif/tb_ex_stage.sv

/* run_sim.sh */
#!/bin/sh
# Build the execute stage testbench with Verilator and run it
# Exit status is 0 only when the run reports a pass

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module tb_ex_stage -f ex_stage.f -o tb_ex_stage
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

out=$(./obj_dir/tb_ex_stage)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -qx "ALL TESTS PASSED"; then
  exit 0
fi
exit 1

/* verif/ex_cases.txt */
# kind op a b c waddr expected lerr, with a b c expected in hex and the rest decimal
# kinds alu br mul off ld bp hold offstall, a load drives a as its read data
alu 0 00000005 00000007 00000000 1 0000000c 0
alu 1 00000003 00000005 00000000 2 fffffffe 0
alu 2 f0f0ff00 0ff0f0f0 00000000 3 00f0f000 0
alu 4 aaaa5555 ffff0000 00000000 5 55555555 0
alu 5 ffffffff 00000001 00000000 6 00000001 0
alu 7 00000003 00000024 00000000 8 00000030 0
alu 9 80000010 00000004 00000000 10 f8000001 0
br 10 12345678 12345678 00001000 0 00000001 0
br 11 00000001 00000001 00002000 0 00000000 0
br 12 fffffff0 00000010 00003000 0 00000001 0
br 13 00000001 80000000 00004000 0 00000001 0
mul 0 00012345 00001000 00000000 11 12345000 0
mul 1 80000000 00000002 00000000 12 ffffffff 0
mul 2 ffffffff ffffffff 00000000 13 fffffffe 0
mul 3 00000003 80000000 00000000 14 00000001 0
off 0 00000010 00000020 00000000 15 00000030 0
off 1 80000001 00000021 00000000 16 00000003 0
off 5 ff00ff00 0f0f0f0f 00000000 17 f00ff00f 0
alu 0 00000100 00000001 00000000 18 00000101 0
ld 0 cafef00d 00000000 00000000 19 cafef00d 0
ld 0 deadbeef 00000000 00000000 20 00000000 1
bp 4 0000ffff 00ff00ff 00000000 21 00ffff00 0
hold 1 00000000 00000000 00000000 0 00000000 0
off 0 00000001 00000002 00000000 22 00000003 0
off 1 00000001 00000004 00000000 23 00000010 0
offstall 6 0000000f 000000f0 00000000 24 000000ff 0
alu 1 00000064 00000001 00000000 25 00000063 0

/* verif/tb_ex_stage.sv */
////////////////////
// Testbench for the execute stage
// Reads commands and expected results from verif/ex_cases.txt,
// models the shared accelerator and prints one summary line
////////////////////

`timescale 1ns/100ps

module tb_ex_stage;

  localparam int NUM_CREDITS = 2;
  localparam int TIMEOUT     = 40;

  logic                    clk = 1'b0;
  logic                    rst_n;
  ex_pkg::ex_cmd_t         cmd_i;
  ex_pkg::rf_wr_t          fw_o;
  ex_pkg::rf_wr_t          wb_o;
  logic                    branch_decision_o;
  logic [ex_pkg::XLEN-1:0] jump_target_o;
  logic                    lsu_ready_ex_i;
  logic [ex_pkg::XLEN-1:0] lsu_rdata_i;
  logic                    lsu_err_i;
  logic                    wb_ready_i;
  ex_pkg::acc_req_t        acc_req_o;
  logic                    acc_credit_i;
  ex_pkg::acc_rsp_t        acc_rsp_i;
  logic                    ex_ready_o;
  logic                    ex_valid_o;

  int                      errors = 0;
  int                      timeouts = 0;
  int                      ncases = 0;
  bit                      hold_credits = 1'b0;
  // Requests in flight and their due cycles, plus results from the file
  ex_pkg::acc_req_t        pend_q[$];
  int                      due_q[$];
  logic [31:0]             exp_q[$];

  always #2 clk = ~clk;

  ex_stage #(
    .NUM_CREDITS (NUM_CREDITS)
  ) u_ex_stage (
    .clk               (clk),
    .rst_n             (rst_n),
    .cmd_i             (cmd_i),
    .fw_o              (fw_o),
    .wb_o              (wb_o),
    .branch_decision_o (branch_decision_o),
    .jump_target_o     (jump_target_o),
    .lsu_ready_ex_i    (lsu_ready_ex_i),
    .lsu_rdata_i       (lsu_rdata_i),
    .lsu_err_i         (lsu_err_i),
    .wb_ready_i        (wb_ready_i),
    .acc_req_o         (acc_req_o),
    .acc_credit_i      (acc_credit_i),
    .acc_rsp_i         (acc_rsp_i),
    .ex_ready_o        (ex_ready_o),
    .ex_valid_o        (ex_valid_o)
  );

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
    if (got !== exp) begin
      $display("CHECK FAILED at %0t: %s, got %h, expected %h", $time, msg, got, exp);
      errors++;
    end
  endtask

  // Op 0 adds, op 1 rotates left and any other op xors
  function automatic logic [31:0] acc_result(input ex_pkg::acc_req_t req);
    logic [4:0] sh;
    sh = req.op_b[4:0];
    if (req.op == 4'd0) begin
      return req.op_a + req.op_b;
    end else if (req.op == 4'd1) begin
      return (req.op_a << sh) | (req.op_a >> (32 - sh));
    end
    return req.op_a ^ req.op_b;
  endfunction

  function automatic ex_pkg::ex_cmd_t build_cmd(input string kind, input int op,
      input logic [31:0] a, input logic [31:0] b, input logic [31:0] c, input int waddr);
    ex_pkg::ex_cmd_t cmd;
    cmd       = '0;
    cmd.op_a  = a;
    cmd.op_b  = b;
    cmd.op_c  = c;
    cmd.waddr = ex_pkg::reg_addr_t'(waddr);
    cmd.we    = 1'b1;
    if (kind == "mul") begin
      cmd.unit    = ex_pkg::UNIT_MULT;
      cmd.mult_op = ex_pkg::mult_op_e'(op[1:0]);
    end else if (kind == "off" || kind == "offstall") begin
      cmd.unit   = ex_pkg::UNIT_OFF;
      cmd.acc_op = op[3:0];
    end else if (kind == "ld") begin
      cmd.unit = ex_pkg::UNIT_LSU;
    end else begin
      cmd.unit   = ex_pkg::UNIT_ALU;
      cmd.alu_op = ex_pkg::alu_op_e'(op[3:0]);
      // Branches only decide, they write nothing
      if (kind == "br") begin
        cmd.is_branch = 1'b1;
        cmd.we        = 1'b0;
      end
    end
    return cmd;
  endfunction

  // Called at a falling edge, returns in the sample phase of the accepting cycle
  task automatic wait_ready(input string kind, output int lows, output bit ok);
    ok   = 1'b0;
    lows = 0;
    for (int i = 0; i < TIMEOUT; i++) begin
      #1;
      if (ex_ready_o) begin
        ok = 1'b1;
        break;
      end
      lows++;
      @(negedge clk);
    end
    if (!ok) begin
      $display("Timeout at %0t: the stage never accepted the %s command", $time, kind);
      timeouts++;
    end
  endtask

  // Idle the stage until every offload result is back
  task automatic drain_acc();
    bit done;
    done = 1'b0;
    for (int i = 0; i < TIMEOUT; i++) begin
      @(negedge clk);
      cmd_i = '0;
      #1;
      if (pend_q.size() == 0 && exp_q.size() == 0) begin
        done = 1'b1;
        break;
      end
    end
    if (!done) begin
      $display("Timeout at %0t: accelerator results did not all come back", $time);
      timeouts++;
    end
  endtask

  task automatic run_case(input string kind, input int op, input logic [31:0] a,
      input logic [31:0] b, input logic [31:0] c, input int waddr,
      input logic [31:0] expv, input int lerr);
    int lows;
    bit ok;
    if (kind == "hold") begin
      drain_acc();
      @(negedge clk);
      hold_credits = (op != 0);
      return;
    end
    // Keep responses off the forward port for cycle-exact checks
    if (kind == "mul" || kind == "bp") begin
      drain_acc();
    end
    @(negedge clk);
    cmd_i     = build_cmd(kind, op, a, b, c, waddr);
    lsu_err_i = (lerr != 0);
    if (kind == "bp") begin
      wb_ready_i = 1'b0;
    end
    ////////////////////
    // Held commands
    ////////////////////
    if (kind == "bp" || kind == "offstall") begin
      repeat (3) begin
        #1;
        check(ex_ready_o, 1'b0, {kind, " command accepted while stalled"});
        if (kind == "offstall") begin
          check(acc_req_o.valid, 1'b0, "request issued without credit");
        end
        @(negedge clk);
      end
      wb_ready_i   = 1'b1;
      hold_credits = 1'b0;
    end
    wait_ready(kind, lows, ok);
    if (!ok) begin
      return;
    end
    if (kind == "br") begin
      check(branch_decision_o, expv[0], "branch decision");
      check(jump_target_o, c, "jump target");
    end else if (kind == "off" || kind == "offstall") begin
      check(acc_req_o.valid, 1'b1, "request valid");
      check(acc_req_o.op, op[3:0], "request op");
      check(acc_req_o.op_a, a, "request op_a");
      check(acc_req_o.op_b, b, "request op_b");
      check(acc_req_o.tag, waddr[4:0], "request tag");
      exp_q.push_back(expv);
    end else if (kind == "ld") begin
      // Read data arrives in the cycle after the load is accepted
      @(negedge clk);
      cmd_i       = '0;
      lsu_err_i   = 1'b0;
      lsu_rdata_i = a;
      #1;
      check(wb_o.we, (lerr == 0), "load write enable");
      if (lerr == 0) begin
        check(wb_o.waddr, waddr[4:0], "load waddr");
        check(wb_o.wdata, expv, "load data");
      end
    end else begin
      if (kind == "mul") begin
        check(lows, (op == 0) ? 0 : 2, "multiplier stall cycles");
      end
      check(ex_valid_o, 1'b1, {kind, " valid"});
      check(fw_o.we, 1'b1, {kind, " forward enable"});
      check(fw_o.waddr, waddr[4:0], {kind, " forward waddr"});
      check(fw_o.wdata, expv, {kind, " forward data"});
    end
  endtask

  ////////////////////
  // Accelerator model
  ////////////////////
  initial begin : acc_model
    ex_pkg::acc_req_t req;
    int               cycle;
    bit               hold_now;
    cycle        = 0;
    hold_now     = 1'b0;
    acc_rsp_i    = '0;
    acc_credit_i = 1'b0;
    void'($urandom(32'hdad0_182d));
    forever begin
      @(negedge clk);
      cycle++;
      acc_rsp_i    = '0;
      acc_credit_i = 1'b0;
      // Oldest request answers first and returns its credit
      if (!hold_now && pend_q.size() != 0 && due_q[0] <= cycle) begin
        req = pend_q.pop_front();
        void'(due_q.pop_front());
        acc_rsp_i.valid  = 1'b1;
        acc_rsp_i.result = acc_result(req);
        acc_rsp_i.tag    = req.tag;
        acc_credit_i     = 1'b1;
      end
      #1;
      hold_now = hold_credits;
      if (acc_rsp_i.valid) begin
        check(ex_valid_o, 1'b1, "valid on response");
        check(fw_o.we, 1'b1, "response forward enable");
        check(fw_o.waddr, acc_rsp_i.tag, "response tag on forward port");
        if (exp_q.size() == 0) begin
          $display("Accelerator returned a result that no offload command expected");
          errors++;
        end else begin
          check(fw_o.wdata, exp_q.pop_front(), "response data on forward port");
        end
      end
      if (rst_n && acc_req_o.valid) begin
        pend_q.push_back(acc_req_o);
        due_q.push_back(cycle + 1 + int'($urandom % 4));
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial begin : main_seq
    int          fd;
    int          cnt;
    string       line;
    string       kind;
    int          op;
    int          waddr;
    int          lerr;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    logic [31:0] expv;
    rst_n          = 1'b0;
    cmd_i          = '0;
    lsu_ready_ex_i = 1'b1;
    lsu_rdata_i    = '0;
    lsu_err_i      = 1'b0;
    wb_ready_i     = 1'b1;
    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check(fw_o.we, 1'b0, "forward enable after reset");
    check(wb_o.we, 1'b0, "writeback enable after reset");
    check(acc_req_o.valid, 1'b0, "request valid after reset");
    check(ex_valid_o, 1'b0, "valid after reset");
    fd = $fopen("verif/ex_cases.txt", "r");
    if (fd == 0) begin
      $display("Could not open the case file verif/ex_cases.txt");
      errors++;
    end else begin
      while ($fgets(line, fd) != 0) begin
        if (line.len() < 2 || line[0] == "#") begin
          continue;
        end
        cnt = $sscanf(line, "%s %d %h %h %h %d %h %d", kind, op, a, b, c, waddr, expv, lerr);
        if (cnt != 8) begin
          $display("Malformed line in the case file: %s", line);
          errors++;
          continue;
        end
        ncases++;
        run_case(kind, op, a, b, c, waddr, expv, lerr);
      end
      $fclose(fd);
    end
    drain_acc();
    $display("Summary: %0d cases, %0d check errors, %0d timeouts", ncases, errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

/* rtl/ex_stage.sv */
////////////////////
// Execute stage top level
// Connects ALU, multiplier, offload dispatcher and result ports
// NUM_CREDITS sets the accelerator request credits
////////////////////

`timescale 1ns/100ps

module ex_stage #(
  parameter int NUM_CREDITS = 2
) (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::ex_cmd_t         cmd_i,
  output ex_pkg::rf_wr_t          fw_o,
  output ex_pkg::rf_wr_t          wb_o,
  output logic                    branch_decision_o,
  output logic [ex_pkg::XLEN-1:0] jump_target_o,
  input  logic                    lsu_ready_ex_i,
  input  logic [ex_pkg::XLEN-1:0] lsu_rdata_i,
  input  logic                    lsu_err_i,
  input  logic                    wb_ready_i,
  output ex_pkg::acc_req_t        acc_req_o,
  input  logic                    acc_credit_i,
  input  ex_pkg::acc_rsp_t        acc_rsp_i,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  logic                    mult_en;
  logic                    off_en;
  logic [ex_pkg::XLEN-1:0] alu_result;
  logic                    alu_cmp;
  logic [ex_pkg::XLEN-1:0] mult_result;
  logic                    mult_ready;
  logic                    disp_ready;
  logic [7:0]              outstanding_q;

  // Unit decode
  assign mult_en = (cmd_i.unit == ex_pkg::UNIT_MULT);
  assign off_en  = (cmd_i.unit == ex_pkg::UNIT_OFF);

  // To fetch
  assign branch_decision_o = alu_cmp & cmd_i.is_branch;
  assign jump_target_o     = cmd_i.op_c;

  ex_alu u_alu (
    .op_i     (cmd_i.alu_op),
    .a_i      (cmd_i.op_a),
    .b_i      (cmd_i.op_b),
    .result_o (alu_result),
    .cmp_o    (alu_cmp)
  );

  ex_mult u_mult (
    .clk        (clk),
    .rst_n      (rst_n),
    .en_i       (mult_en),
    .op_i       (cmd_i.mult_op),
    .a_i        (cmd_i.op_a),
    .b_i        (cmd_i.op_b),
    .ex_ready_i (ex_ready_o),
    .result_o   (mult_result),
    .ready_o    (mult_ready)
  );

  ex_offload_disp #(
    .NUM_CREDITS (NUM_CREDITS)
  ) u_offload_disp (
    .clk          (clk),
    .rst_n        (rst_n),
    .en_i         (off_en),
    .cmd_i        (cmd_i),
    .ex_ready_i   (ex_ready_o),
    .acc_credit_i (acc_credit_i),
    .acc_req_o    (acc_req_o),
    .ready_o      (disp_ready)
  );

  ex_writeback u_writeback (
    .clk            (clk),
    .rst_n          (rst_n),
    .cmd_i          (cmd_i),
    .alu_result_i   (alu_result),
    .mult_result_i  (mult_result),
    .mult_ready_i   (mult_ready),
    .disp_ready_i   (disp_ready),
    .acc_rsp_i      (acc_rsp_i),
    .lsu_ready_ex_i (lsu_ready_ex_i),
    .lsu_rdata_i    (lsu_rdata_i),
    .lsu_err_i      (lsu_err_i),
    .wb_ready_i     (wb_ready_i),
    .fw_o           (fw_o),
    .wb_o           (wb_o),
    .ex_ready_o     (ex_ready_o),
    .ex_valid_o     (ex_valid_o)
  );

  ////////////////////
  // Outstanding requests, seen from the ports
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      outstanding_q <= '0;
    end else begin
      outstanding_q <= outstanding_q + 8'(acc_req_o.valid) - 8'(acc_rsp_i.valid);
    end
  end

  rsp_expected_a: assert property (@(posedge clk) disable iff (!rst_n)
    acc_rsp_i.valid |-> (outstanding_q != '0))
    else $error("accelerator response without outstanding request");

endmodule

/* rtl/ex_writeback.sv */
////////////////////
// Result ports and stage handshake
// Accelerator responses win the forward port, loads go
// through the EX/WB register to the writeback port
////////////////////

`timescale 1ns/100ps

module ex_writeback (
  input  logic                    clk,
  input  logic                    rst_n,
  input  ex_pkg::ex_cmd_t         cmd_i,
  input  logic [ex_pkg::XLEN-1:0] alu_result_i,
  input  logic [ex_pkg::XLEN-1:0] mult_result_i,
  input  logic                    mult_ready_i,
  input  logic                    disp_ready_i,
  input  ex_pkg::acc_rsp_t        acc_rsp_i,
  input  logic                    lsu_ready_ex_i,
  input  logic [ex_pkg::XLEN-1:0] lsu_rdata_i,
  input  logic                    lsu_err_i,
  input  logic                    wb_ready_i,
  output ex_pkg::rf_wr_t          fw_o,
  output ex_pkg::rf_wr_t          wb_o,
  output logic                    ex_ready_o,
  output logic                    ex_valid_o
);

  logic              fw_req;
  logic              contention;
  logic              consumed;
  logic              lsu_wr;
  logic              lsu_we_q;
  ex_pkg::reg_addr_t lsu_waddr_q;

  // ALU and MUL write at once, high products only when done
  assign fw_req = cmd_i.we & ((cmd_i.unit == ex_pkg::UNIT_ALU) |
                              ((cmd_i.unit == ex_pkg::UNIT_MULT) & mult_ready_i));

  assign contention = acc_rsp_i.valid & fw_req;

  ////////////////////
  // Forward port mux
  ////////////////////
  always_comb begin
    if (acc_rsp_i.valid) begin
      fw_o = '{we: 1'b1, waddr: acc_rsp_i.tag, wdata: acc_rsp_i.result};
    end else begin
      fw_o.we    = fw_req;
      fw_o.waddr = cmd_i.waddr;
      fw_o.wdata = (cmd_i.unit == ex_pkg::UNIT_MULT) ? mult_result_i : alu_result_i;
    end
  end

  // Branches always finish in EX
  assign ex_ready_o = (~contention & mult_ready_i & disp_ready_i & lsu_ready_ex_i &
                       wb_ready_i) | cmd_i.is_branch;
  assign consumed   = (cmd_i.unit != ex_pkg::UNIT_NONE) & ex_ready_o;
  assign ex_valid_o = consumed | acc_rsp_i.valid;

  // Load error drops the write
  assign lsu_wr = consumed & (cmd_i.unit == ex_pkg::UNIT_LSU) & cmd_i.we & ~lsu_err_i;

  ////////////////////
  // EX/WB register
  ////////////////////
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      lsu_we_q <= 1'b0;
    end else if (wb_ready_i) begin
      lsu_we_q <= lsu_wr;
    end
  end

  always_ff @(posedge clk) begin
    if (wb_ready_i && lsu_wr) begin
      lsu_waddr_q <= cmd_i.waddr;
    end
  end

  // Load data arrives from the LSU one cycle later
  assign wb_o = '{we: lsu_we_q, waddr: lsu_waddr_q, wdata: lsu_rdata_i};

  fw_no_x0_a: assert property (@(posedge clk) disable iff (!rst_n)
    fw_o.we |-> (fw_o.waddr != '0))
    else $error("forward write to x0");

endmodule

/* rtl/ex_offload_disp.sv */
////////////////////
// Offload dispatcher for the shared accelerator
// Issues one request per consumed offload command against
// a credit counter, credits come back as single-cycle pulses
////////////////////

`timescale 1ns/100ps

module ex_offload_disp #(
  parameter int NUM_CREDITS = 2
) (
  input  logic             clk,
  input  logic             rst_n,
  input  logic             en_i,
  input  ex_pkg::ex_cmd_t  cmd_i,
  input  logic             ex_ready_i,
  input  logic             acc_credit_i,
  output ex_pkg::acc_req_t acc_req_o,
  output logic             ready_o
);

  localparam int CW = $clog2(NUM_CREDITS + 1);

  logic [CW-1:0] credits_q;
  logic [CW-1:0] credits_d;
  logic          issue;

  // Request goes out in the cycle the command is consumed
  assign issue = en_i & ex_ready_i;

  always_comb begin
    credits_d = credits_q;
    if (issue) begin
      credits_d = credits_d - 1'b1;
    end
    if (acc_credit_i) begin
      credits_d = credits_d + 1'b1;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      credits_q <= CW'(NUM_CREDITS);
    end else begin
      credits_q <= credits_d;
    end
  end

  // Stall an offload command until a credit is available
  assign ready_o = ~en_i | (credits_q != '0);

  ////////////////////
  // Request channel
  ////////////////////
  assign acc_req_o.valid = issue;
  assign acc_req_o.op    = cmd_i.acc_op;
  assign acc_req_o.op_a  = cmd_i.op_a;
  assign acc_req_o.op_b  = cmd_i.op_b;
  // Destination register travels as the tag
  assign acc_req_o.tag   = cmd_i.waddr;

  credits_max_a: assert property (@(posedge clk) disable iff (!rst_n)
    credits_q <= CW'(NUM_CREDITS))
    else $error("more credits returned than issued");

  no_credit_issue_a: assert property (@(posedge clk) disable iff (!rst_n)
    issue |-> (credits_q != '0))
    else $error("accelerator request issued without credit");

endmodule

/* rtl/ex_mult.sv */
////////////////////
// Integer multiplier
// MUL is combinational, the high products take three cycles
// and hold ready low for the first two
////////////////////

`timescale 1ns/100ps

module ex_mult (
  input  logic                    clk,
  input  logic                    rst_n,
  input  logic                    en_i,
  input  ex_pkg::mult_op_e        op_i,
  input  logic [ex_pkg::XLEN-1:0] a_i,
  input  logic [ex_pkg::XLEN-1:0] b_i,
  input  logic                    ex_ready_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    ready_o
);

  typedef enum logic [1:0] {S_IDLE, S_LO, S_HI} state_e;

  state_e              state_q;
  logic                start;
  logic signed [32:0]  a_q;
  logic signed [32:0]  b_q;
  logic signed [65:0]  acc_q;
  logic signed [65:0]  hi_part;
  logic signed [65:0]  prod;

  // High product requested from idle
  assign start = en_i & (op_i != ex_pkg::MUL);

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= S_IDLE;
    end else begin
      unique case (state_q)
        S_IDLE:  if (start) state_q <= S_LO;
        S_LO:    state_q <= S_HI;
        // Leave once the stage consumes the result
        S_HI:    if (ex_ready_i) state_q <= S_IDLE;
        default: state_q <= S_IDLE;
      endcase
    end
  end

  // Operand capture and first partial product
  always_ff @(posedge clk) begin
    if (state_q == S_IDLE && start) begin
      a_q <= {(op_i != ex_pkg::MULHU) & a_i[31], a_i};
      b_q <= {(op_i == ex_pkg::MULH) & b_i[31], b_i};
    end
    if (state_q == S_LO) begin
      // a times the unsigned low half of b
      acc_q <= a_q * $signed({1'b0, b_q[15:0]});
    end
  end

  // Signed upper half of b added in the last cycle
  assign hi_part = a_q * $signed(b_q[32:16]);
  assign prod    = acc_q + (hi_part <<< 16);

  assign result_o = (state_q == S_HI) ? prod[63:32] : a_i * b_i;
  assign ready_o  = (state_q == S_HI) | ((state_q == S_IDLE) & ~start);

  // Decode must hold the command while the FSM works on it
  op_stable_a: assert property (@(posedge clk) disable iff (!rst_n)
    (state_q != S_IDLE) |-> $stable(op_i))
    else $error("multiplier op changed while busy");

endmodule

/* rtl/ex_alu.sv */
////////////////////
// Integer ALU of the execute stage
// Purely combinational, also produces the branch comparison
////////////////////

`timescale 1ns/100ps

module ex_alu (
  input  ex_pkg::alu_op_e         op_i,
  input  logic [ex_pkg::XLEN-1:0] a_i,
  input  logic [ex_pkg::XLEN-1:0] b_i,
  output logic [ex_pkg::XLEN-1:0] result_o,
  output logic                    cmp_o
);

  logic       eq;
  logic       lt_s;
  logic       lt_u;
  logic [4:0] shamt;

  // Shared comparators for slt, sltu and the branches
  assign eq    = (a_i == b_i);
  assign lt_s  = ($signed(a_i) < $signed(b_i));
  assign lt_u  = (a_i < b_i);
  // Only the low five bits count for shifts
  assign shamt = b_i[4:0];

  always_comb begin
    result_o = '0;
    cmp_o    = 1'b0;
    unique case (op_i)
      ex_pkg::ALU_ADD:  result_o = a_i + b_i;
      ex_pkg::ALU_SUB:  result_o = a_i - b_i;
      ex_pkg::ALU_AND:  result_o = a_i & b_i;
      ex_pkg::ALU_OR:   result_o = a_i | b_i;
      ex_pkg::ALU_XOR:  result_o = a_i ^ b_i;
      ex_pkg::ALU_SLT:  result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_s};
      ex_pkg::ALU_SLTU: result_o = {{(ex_pkg::XLEN-1){1'b0}}, lt_u};
      ex_pkg::ALU_SLL:  result_o = a_i << shamt;
      ex_pkg::ALU_SRL:  result_o = a_i >> shamt;
      // Arithmetic shift keeps the sign
      ex_pkg::ALU_SRA:  result_o = $unsigned($signed(a_i) >>> shamt);
      ////////////////////
      // Branch compares
      ////////////////////
      ex_pkg::ALU_EQ:   cmp_o = eq;
      ex_pkg::ALU_NE:   cmp_o = ~eq;
      ex_pkg::ALU_LT:   cmp_o = lt_s;
      ex_pkg::ALU_GE:   cmp_o = ~lt_s;
      default: begin
        result_o = '0;
        cmp_o    = 1'b0;
      end
    endcase
  end

endmodule

/* rtl/ex_pkg.sv */
////////////////////
// Shared types for the execute stage
// Holds the data width, the decode command, the register file write
// and the accelerator request and response channels
////////////////////

package ex_pkg;

  localparam int XLEN = 32;

  typedef logic [4:0] reg_addr_t;
  typedef logic [3:0] acc_op_t;

  // Unit that runs a command
  typedef enum logic [2:0] {
    UNIT_NONE = 3'd0,
    UNIT_ALU  = 3'd1,
    UNIT_MULT = 3'd2,
    UNIT_OFF  = 3'd3,
    UNIT_LSU  = 3'd4
  } unit_e;

  // Integer ops first, branch compares from 10 up
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13
  } alu_op_e;

  typedef enum logic [1:0] {
    MUL    = 2'd0,
    MULH   = 2'd1,
    MULHU  = 2'd2,
    MULHSU = 2'd3
  } mult_op_e;

  // One command from decode
  typedef struct packed {
    unit_e           unit;
    alu_op_e         alu_op;
    mult_op_e        mult_op;
    acc_op_t         acc_op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] op_c;
    logic            is_branch;
    reg_addr_t       waddr;
    logic            we;
  } ex_cmd_t;

  typedef struct packed {
    logic            we;
    reg_addr_t       waddr;
    logic [XLEN-1:0] wdata;
  } rf_wr_t;

  // Tag carries the destination register
  typedef struct packed {
    logic            valid;
    acc_op_t         op;
    logic [XLEN-1:0] op_a;
    logic [XLEN-1:0] op_b;
    reg_addr_t       tag;
  } acc_req_t;

  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] result;
    reg_addr_t       tag;
  } acc_rsp_t;

endpackage
